//--- hdl/rv_core_pkg.sv
// Shared widths, reset values and encodings for the multicycle RV32I core; RV32I subset only
package rv_core_pkg;

    localparam int xlen       = 32;                   // Data and address width
    localparam int reg_addr_w = 5;                    // Register index width
    localparam int dmem_words = 256;                  // Data memory depth in words
    localparam int dmem_idx_w = $clog2(dmem_words);   // Word index width into data memory

    localparam logic [xlen-1:0] start_addr = 32'h8000_0000;  // PC after reset
    localparam logic [xlen-1:0] nop_instr  = 32'h0000_0013;  // ADDI x0,x0,0

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b                                    // Used by LUI
    } alu_op_e;

    // One state per clock, st_mem only for loads and stores
    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_mem,
        st_wb
    } state_e;

endpackage

//--- hdl/rv_sequencer.sv
// Instruction phase FSM; one state per clock, no stalls and no back-pressure
`timescale 1ns/10ps

module rv_sequencer (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic is_mem_i,      // Load or store, needs st_mem
    input  logic is_store_i,
    input  logic writes_rd_i,   // Nonzero rd is written
    output logic ir_load_o,
    output logic alu_load_o,
    output logic dmem_we_o,
    output logic rf_we_o,
    output logic pc_load_o,
    output logic update_o
);

    rv_core_pkg::state_e state, state_next;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state <= rv_core_pkg::st_fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            rv_core_pkg::st_fetch:  state_next = rv_core_pkg::st_decode;
            rv_core_pkg::st_decode: state_next = rv_core_pkg::st_exec;
            rv_core_pkg::st_exec: begin
                state_next = is_mem_i ? rv_core_pkg::st_mem : rv_core_pkg::st_wb;
            end
            rv_core_pkg::st_mem:    state_next = rv_core_pkg::st_wb;
            default:                state_next = rv_core_pkg::st_fetch;
        endcase
    end

    // Strobes are plain state decodes
    assign ir_load_o  = (state == rv_core_pkg::st_fetch);
    assign alu_load_o = (state == rv_core_pkg::st_exec);
    assign dmem_we_o  = (state == rv_core_pkg::st_mem) && is_store_i;
    assign rf_we_o    = (state == rv_core_pkg::st_wb) && writes_rd_i;
    assign pc_load_o  = (state == rv_core_pkg::st_wb);
    assign update_o   = (state == rv_core_pkg::st_wb);   // Retire pulse, one cycle

endmodule

//--- hdl/rv_pc.sv
// Program counter; branch and JAL targets are PC relative only, no JALR
`timescale 1ns/10ps

module rv_pc (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         pc_load_i,
    input  logic [rv_core_pkg::xlen-1:0] imm_i,        // B or J offset
    input  logic                         is_branch_i,
    input  logic                         is_jal_i,
    input  logic                         cond_i,       // Branch condition from ALU
    output logic [rv_core_pkg::xlen-1:0] pc_o,
    output logic [rv_core_pkg::xlen-1:0] link_o        // Return address for JAL
);

    logic take;

    assign take   = is_jal_i | (is_branch_i & cond_i);
    assign link_o = pc_o + 32'd4;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_o <= rv_core_pkg::start_addr;
        end else if (pc_load_i) begin
            pc_o <= take ? pc_o + imm_i : link_o;
        end
    end

endmodule

//--- hdl/rv_decoder.sv
// Instruction register and decode; opcodes outside the subset retire as a NOP
`timescale 1ns/10ps

module rv_decoder (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic                               ir_load_i,
    input  logic [rv_core_pkg::xlen-1:0]       instr_i,
    output logic [rv_core_pkg::xlen-1:0]       instr_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs1_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs2_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rd_o,
    output logic [rv_core_pkg::xlen-1:0]       imm_o,
    output rv_core_pkg::alu_op_e               alu_op_o,
    output logic                               sel_imm_o,    // ALU B operand is the immediate
    output logic                               is_mem_o,
    output logic                               is_store_o,
    output logic                               is_branch_o,
    output logic                               is_jal_o,
    output logic                               writes_rd_o,
    output logic [1:0]                         wb_sel_o      // {link, from memory}
);

    logic [rv_core_pkg::xlen-1:0] ir;
    logic [2:0] funct3;
    logic writes;
    rv_core_pkg::opcode_e opcode;
    rv_core_pkg::alu_op_e arith_op;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ir <= rv_core_pkg::nop_instr;
        end else if (ir_load_i) begin
            ir <= instr_i;
        end
    end

    assign instr_o = ir;
    assign opcode  = rv_core_pkg::opcode_e'(ir[6:0]);
    assign funct3  = ir[14:12];
    assign rs1_o   = ir[19:15];
    assign rs2_o   = ir[24:20];
    assign rd_o    = ir[11:7];

    // Register and immediate arithmetic share funct3, bit 30 picks SUB and SRA
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == rv_core_pkg::op_reg && ir[30]) ?
                                rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
            3'b001:  arith_op = rv_core_pkg::alu_sll;
            3'b010:  arith_op = rv_core_pkg::alu_slt;
            3'b011:  arith_op = rv_core_pkg::alu_sltu;
            3'b100:  arith_op = rv_core_pkg::alu_xor;
            3'b101:  arith_op = ir[30] ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
            3'b110:  arith_op = rv_core_pkg::alu_or;
            default: arith_op = rv_core_pkg::alu_and;
        endcase
    end

    always_comb begin
        alu_op_o    = rv_core_pkg::alu_add;
        imm_o       = {{20{ir[31]}}, ir[31:20]};                        // I type
        sel_imm_o   = 1'b0;
        is_mem_o    = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        writes      = 1'b0;
        wb_sel_o    = 2'b00;
        case (opcode)
            rv_core_pkg::op_lui: begin
                imm_o     = {ir[31:12], 12'b0};
                alu_op_o  = rv_core_pkg::alu_pass_b;
                sel_imm_o = 1'b1;
                writes    = 1'b1;
            end
            rv_core_pkg::op_imm: begin
                alu_op_o  = arith_op;
                sel_imm_o = 1'b1;
                writes    = 1'b1;
            end
            rv_core_pkg::op_reg: begin
                alu_op_o = arith_op;
                writes   = 1'b1;
            end
            rv_core_pkg::op_load: begin
                sel_imm_o = 1'b1;                                       // rs1 plus offset
                is_mem_o  = 1'b1;
                writes    = 1'b1;
                wb_sel_o  = 2'b01;
            end
            rv_core_pkg::op_store: begin
                imm_o      = {{20{ir[31]}}, ir[31:25], ir[11:7]};
                sel_imm_o  = 1'b1;
                is_mem_o   = 1'b1;
                is_store_o = 1'b1;
            end
            rv_core_pkg::op_branch: begin
                imm_o       = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
                alu_op_o    = funct3[2] ? rv_core_pkg::alu_slt : rv_core_pkg::alu_sub;
                is_branch_o = 1'b1;
            end
            rv_core_pkg::op_jal: begin
                imm_o    = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
                is_jal_o = 1'b1;
                writes   = 1'b1;
                wb_sel_o = 2'b10;
            end
            default: ;                                                  // Treated as NOP
        endcase
    end

    assign writes_rd_o = writes && (rd_o != '0);

endmodule

//--- hdl/rv_regfile.sv
// 32 x 32-bit register file, reads are combinational and x0 always reads zero
`timescale 1ns/10ps

module rv_regfile (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rs1_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rs2_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rd_i,
    input  logic                               we_i,
    input  logic [rv_core_pkg::xlen-1:0]       rd_data_i,
    output logic [rv_core_pkg::xlen-1:0]       rs1_data_o,
    output logic [rv_core_pkg::xlen-1:0]       rs2_data_o
);

    logic [rv_core_pkg::xlen-1:0] regs [1:31];   // No storage behind x0

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- hdl/rv_alu.sv
// ALU with registered result; cond_o is combinational and assumes a branch funct3
`timescale 1ns/10ps

module rv_alu (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         alu_load_i,
    input  rv_core_pkg::alu_op_e         op_i,
    input  logic [rv_core_pkg::xlen-1:0] a_i,
    input  logic [rv_core_pkg::xlen-1:0] b_i,
    input  logic [2:0]                   funct3_i,   // Branch type, bit 0 inverts
    output logic [rv_core_pkg::xlen-1:0] result_o,
    output logic                         cond_o
);

    logic [rv_core_pkg::xlen-1:0] result;
    logic lt, eq;

    assign lt = $signed(a_i) < $signed(b_i);
    assign eq = (a_i == b_i);

    always_comb begin
        case (op_i)
            rv_core_pkg::alu_add:    result = a_i + b_i;
            rv_core_pkg::alu_sub:    result = a_i - b_i;
            rv_core_pkg::alu_and:    result = a_i & b_i;
            rv_core_pkg::alu_or:     result = a_i | b_i;
            rv_core_pkg::alu_xor:    result = a_i ^ b_i;
            rv_core_pkg::alu_slt:    result = {31'b0, lt};
            rv_core_pkg::alu_sltu:   result = {31'b0, a_i < b_i};
            rv_core_pkg::alu_sll:    result = a_i << b_i[4:0];
            rv_core_pkg::alu_srl:    result = a_i >> b_i[4:0];
            rv_core_pkg::alu_sra:    result = $unsigned($signed(a_i) >>> b_i[4:0]);
            default:                 result = b_i;                     // pass_b
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            result_o <= '0;
        end else if (alu_load_i) begin
            result_o <= result;
        end
    end

    // BEQ/BNE compare equal, BLT/BGE compare signed less than
    assign cond_o = (funct3_i[2] ? lt : eq) ^ funct3_i[0];

endmodule

//--- hdl/rv_dmem.sv
// Word-only data memory; addresses wrap modulo depth and byte offsets are ignored
`timescale 1ns/10ps

module rv_dmem (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         we_i,
    input  logic [rv_core_pkg::xlen-1:0] addr_i,       // Byte address
    input  logic [rv_core_pkg::xlen-1:0] wdata_i,
    input  logic [rv_core_pkg::xlen-1:0] dbg_addr_i,   // Byte address
    output logic [rv_core_pkg::xlen-1:0] rdata_o,
    output logic [rv_core_pkg::xlen-1:0] dbg_data_o
);

    logic [rv_core_pkg::xlen-1:0] mem [rv_core_pkg::dmem_words];
    logic [rv_core_pkg::dmem_idx_w-1:0] idx, dbg_idx;

    assign idx     = addr_i[rv_core_pkg::dmem_idx_w+1:2];
    assign dbg_idx = dbg_addr_i[rv_core_pkg::dmem_idx_w+1:2];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[idx] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= mem[idx];                         // Valid the cycle after st_mem
        end
    end

    assign dbg_data_o = mem[dbg_idx];

endmodule

//--- hdl/rv_core.sv
// Multicycle RV32I subset core; imem_data_i must be valid in the same cycle as imem_addr_o
`timescale 1ns/10ps

module rv_core (
    input  logic                                 clk_i,
    input  logic                                 rstn_i,
    input  logic [rv_core_pkg::xlen-1:0]         imem_data_i,  // Instruction at imem_addr_o
    input  logic [rv_core_pkg::xlen-1:0]         addr_i,       // Debug read address, bytes
    output logic [rv_core_pkg::xlen-1:0]         imem_addr_o,
    output logic [rv_core_pkg::xlen-1:0]         data_o,       // Debug read data
    output logic                                 update_o,     // High in the writeback cycle
    output logic [rv_core_pkg::xlen-1:0]         pc_o,
    output logic [rv_core_pkg::xlen-1:0]         instr_o,
    output logic [rv_core_pkg::reg_addr_w-1:0]   reg_addr_o,
    output logic [rv_core_pkg::xlen-1:0]         reg_data_o,
    output logic [rv_core_pkg::xlen-1:0]         mem_addr_o,
    output logic [rv_core_pkg::xlen-1:0]         mem_data_o,
    output logic                                 mem_wrt_o
);

    logic ir_load, alu_load, dmem_we, rf_we, pc_load;
    logic is_mem, is_store, is_branch, is_jal, writes_rd, sel_imm, cond;
    logic [1:0] wb_sel;                                    // {link, from memory}
    logic [rv_core_pkg::reg_addr_w-1:0] rs1, rs2, rd;
    logic [rv_core_pkg::xlen-1:0] instr, imm, pc, link;
    logic [rv_core_pkg::xlen-1:0] rs1_data, rs2_data, alu_b, alu_result, load_data, wb_data;
    rv_core_pkg::alu_op_e alu_op;

    rv_sequencer u_sequencer (
        .clk_i, .rstn_i,
        .is_mem_i(is_mem), .is_store_i(is_store), .writes_rd_i(writes_rd),
        .ir_load_o(ir_load), .alu_load_o(alu_load), .dmem_we_o(dmem_we),
        .rf_we_o(rf_we), .pc_load_o(pc_load), .update_o(update_o)
    );

    rv_pc u_pc (
        .clk_i, .rstn_i,
        .pc_load_i(pc_load), .imm_i(imm), .is_branch_i(is_branch), .is_jal_i(is_jal),
        .cond_i(cond), .pc_o(pc), .link_o(link)
    );

    rv_decoder u_decoder (
        .clk_i, .rstn_i,
        .ir_load_i(ir_load), .instr_i(imem_data_i), .instr_o(instr),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm), .alu_op_o(alu_op),
        .sel_imm_o(sel_imm), .is_mem_o(is_mem), .is_store_o(is_store),
        .is_branch_o(is_branch), .is_jal_o(is_jal), .writes_rd_o(writes_rd),
        .wb_sel_o(wb_sel)
    );

    rv_regfile u_regfile (
        .clk_i, .rstn_i,
        .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .we_i(rf_we), .rd_data_i(wb_data),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    assign alu_b = sel_imm ? imm : rs2_data;               // Immediate or rs2 operand

    rv_alu u_alu (
        .clk_i, .rstn_i,
        .alu_load_i(alu_load), .op_i(alu_op), .a_i(rs1_data), .b_i(alu_b),
        .funct3_i(instr[14:12]), .result_o(alu_result), .cond_o(cond)
    );

    rv_dmem u_dmem (
        .clk_i, .rstn_i,
        .we_i(dmem_we), .addr_i(alu_result), .wdata_i(rs2_data), .rdata_o(load_data),
        .dbg_addr_i(addr_i), .dbg_data_o(data_o)
    );

    // Writeback source select, link wins over memory
    always_comb begin
        if (wb_sel[1]) begin
            wb_data = link;
        end else if (wb_sel[0]) begin
            wb_data = load_data;
        end else begin
            wb_data = alu_result;
        end
    end

    assign imem_addr_o = pc;

    // Retire trace, PC still points at the retiring instruction during st_wb
    assign pc_o       = pc;
    assign instr_o    = instr;
    assign reg_addr_o = rf_we ? rd : '0;                   // rf_we already excludes x0
    assign reg_data_o = rf_we ? wb_data : '0;
    assign mem_wrt_o  = update_o & is_store;
    assign mem_addr_o = mem_wrt_o ? alu_result : '0;
    assign mem_data_o = mem_wrt_o ? rs2_data : '0;

endmodule

//--- test/tb_clock.sv
// Testbench clock and reset; 10 ns period, reset held low for the first 5 rising edges
`timescale 1ns/10ps

module tb_clock (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rstn_o <= 1'b1;                                 // Released on a rising edge
    end

    always #5 clk_o = ~clk_o;

endmodule

//--- test/tb_rv_core.sv
// Random-program testbench; loads and stores stay in an 8-word window that a store prologue clears
`timescale 1ns/10ps

module tb_rv_core;

    localparam int prog_len       = 64;
    localparam int win_words      = 8;                  // Data words the program touches
    localparam int timeout_cycles = prog_len * 5 + 20;

    logic clk, rstn, update, mem_wrt;
    logic [rv_core_pkg::xlen-1:0] imem_data, addr, imem_addr, data, pc, instr;
    logic [rv_core_pkg::xlen-1:0] reg_data, mem_addr, mem_data;
    logic [rv_core_pkg::reg_addr_w-1:0] reg_addr;

    logic [31:0] prog [prog_len];
    logic [31:0] mregs [32];                            // Model register file
    logic [31:0] mmem [rv_core_pkg::dmem_words];        // Model data memory
    logic [31:0] mpc;
    int errors, checks, cycles, last_update;
    bit done;

    tb_clock u_clock (.clk_o(clk), .rstn_o(rstn));

    rv_core dut (
        .clk_i(clk), .rstn_i(rstn), .imem_data_i(imem_data), .addr_i(addr),
        .imem_addr_o(imem_addr), .data_o(data), .update_o(update), .pc_o(pc),
        .instr_o(instr), .reg_addr_o(reg_addr), .reg_data_o(reg_data),
        .mem_addr_o(mem_addr), .mem_data_o(mem_data), .mem_wrt_o(mem_wrt)
    );

    function automatic bit in_program(input logic [31:0] a);
        return a >= rv_core_pkg::start_addr && a < rv_core_pkg::start_addr + 4 * prog_len;
    endfunction

    function automatic logic [5:0] prog_index(input logic [31:0] a);
        logic [31:0] offset;
        offset = a - rv_core_pkg::start_addr;
        return offset[7:2];
    endfunction

    // Instruction port answers in the same cycle
    always_comb begin
        if (in_program(imem_addr)) begin
            imem_data = prog[prog_index(imem_addr)];
        end else begin
            imem_data = rv_core_pkg::nop_instr;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [20:0] off;
        logic [11:0] woff;
        logic [2:0] f3;
        int kind, rem, lim;
        for (int i = 0; i < prog_len; i++) begin
            r    = $urandom;
            kind = $urandom % 16;
            rem  = prog_len - 1 - i;
            lim  = (rem < 4) ? rem : 4;
            woff = {7'b0, r[17:15], 2'b00};                         // Inside the data window
            f3   = r[29:27];
            if (kind >= 13 && rem == 0) begin
                kind = 1;                                           // No forward target left
            end
            if (i < win_words) begin
                prog[i[5:0]] = {7'b0, 5'd0, 5'd0, 3'b010, 5'(4 * i), rv_core_pkg::op_store};
                continue;
            end
            case (kind)
                0: prog[i[5:0]] = {r[31:12], r[4:0], rv_core_pkg::op_lui};
                1, 2, 3, 4: begin
                    if (f3 == 3'b001 || f3 == 3'b011 || f3 == 3'b101) begin
                        f3 = 3'b000;                                // ADDI/SLTI/XORI/ORI/ANDI only
                    end
                    prog[i[5:0]] = {r[26:15], r[9:5], f3, r[4:0], rv_core_pkg::op_imm};
                end
                5, 6, 7, 8: begin
                    prog[i[5:0]] = {1'b0, r[30] && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                                    r[14:10], r[9:5], f3, r[4:0], rv_core_pkg::op_reg};
                end
                9, 10: prog[i[5:0]] = {woff, 5'd0, 3'b010, r[4:0], rv_core_pkg::op_load};
                11, 12: begin
                    prog[i[5:0]] = {woff[11:5], r[14:10], 5'd0, 3'b010, woff[4:0],
                                    rv_core_pkg::op_store};
                end
                13, 14: begin
                    off = 21'(4 * (1 + $urandom % lim));
                    prog[i[5:0]] = {off[12], off[10:5], r[14:10], r[9:5], r[28], 1'b0, r[27],
                                    off[4:1], off[11], rv_core_pkg::op_branch};
                end
                default: begin
                    off = 21'(4 * (1 + $urandom % lim));
                    prog[i[5:0]] = {off[20], off[10:1], off[11], off[19:12], r[4:0],
                                    rv_core_pkg::op_jal};
                end
            endcase
        end
    endtask

    // Steps the model by one instruction and compares the retire outputs
    task automatic retire_check();
        logic [31:0] ins, a, b, imm_i, imm_s, imm_b, imm_j, res;
        logic [4:0] rd;
        logic [2:0] f3;
        logic wr, st, take, is_mem;
        ins    = prog[prog_index(mpc)];
        a      = mregs[ins[19:15]];
        b      = mregs[ins[24:20]];
        f3     = ins[14:12];
        rd     = ins[11:7];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        res    = '0;
        wr     = 1'b1;
        st     = 1'b0;
        take   = 1'b0;
        is_mem = 1'b0;
        case (ins[6:0])
            rv_core_pkg::op_lui:  res = {ins[31:12], 12'b0};
            rv_core_pkg::op_imm:  res = arith(f3, ins[30] && f3 == 3'b101, a, imm_i);
            rv_core_pkg::op_reg:  res = arith(f3, ins[30], a, b);
            rv_core_pkg::op_load: begin
                res    = mmem[8'((a + imm_i) >> 2)];
                is_mem = 1'b1;
            end
            rv_core_pkg::op_store: begin
                wr     = 1'b0;
                st     = 1'b1;
                is_mem = 1'b1;
            end
            rv_core_pkg::op_branch: begin
                wr   = 1'b0;
                take = (f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b) ||
                       (f3 == 3'b100 && $signed(a) < $signed(b)) ||
                       (f3 == 3'b101 && $signed(a) >= $signed(b));
            end
            rv_core_pkg::op_jal: begin
                res  = mpc + 4;
                take = 1'b1;
            end
            default: wr = 1'b0;
        endcase
        wr = wr && rd != 5'd0;
        check_value("pc_o", pc, mpc);
        check_value("imem_addr_o", imem_addr, mpc);
        check_value("instr_o", instr, ins);
        check_value("reg_addr_o", {27'b0, reg_addr}, wr ? {27'b0, rd} : 32'b0);
        check_value("reg_data_o", reg_data, wr ? res : 32'b0);
        check_value("mem_wrt_o", {31'b0, mem_wrt}, {31'b0, st});
        check_value("mem_addr_o", mem_addr, st ? a + imm_s : 32'b0);
        check_value("mem_data_o", mem_data, st ? b : 32'b0);
        if (last_update >= 0) begin
            check_value("update_o interval", cycles - last_update, is_mem ? 5 : 4);
        end
        last_update = cycles;
        if (wr) begin
            mregs[rd] = res;
        end
        if (st) begin
            mmem[8'((a + imm_s) >> 2)] = b;                             // Wraps modulo depth
        end
        mpc  = take ? mpc + ((ins[6:0] == rv_core_pkg::op_jal) ? imm_j : imm_b) : mpc + 4;
        done = !in_program(mpc);
    endtask

    initial begin
        void'($urandom(32'h2c66));
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        last_update = -1;
        done        = 1'b0;
        addr        = '0;
        mpc         = rv_core_pkg::start_addr;
        for (int i = 0; i < 32; i++) begin
            mregs[i[4:0]] = '0;
        end
        build_program();
        wait (rstn === 1'b1);
        while (!done && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            if (update === 1'b1) begin
                retire_check();
            end
        end
        if (!done) begin
            errors++;
            $display("Error: the program did not finish within %0d cycles", timeout_cycles);
        end
        for (int w = 0; w < rv_core_pkg::dmem_words; w++) begin
            @(posedge clk);
            addr <= 32'(w * 4);
            @(negedge clk);
            check_value($sformatf("data_o word %0d", w), data, mmem[w[7:0]]);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- rv_core.f
hdl/rv_core_pkg.sv
hdl/rv_sequencer.sv
hdl/rv_pc.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_dmem.sv
hdl/rv_core.sv
test/tb_clock.sv
test/tb_rv_core.sv

//--- Makefile
# Verilator build and run; any variable can be set on the command line
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@! grep -q "sim failed" $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
